// File: verilog.f
+incdir+.
des_pkg.sv
des_round.sv
des_round_group.sv
des_key_schedule.sv
des_core.sv
tb_des.sv

// File: run_sim.sh
#!/bin/sh
# Build the DES testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal -f verilog.f --top-module tb_des -o tb_des_sim

# The log decides pass or fail, not the exit status of the run
./obj_dir/tb_des_sim 2>&1 | tee sim.log

if grep -q "TB PASSED" sim.log; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed, see sim.log"
    exit 1
fi

// File: tb_des.sv
`timescale 1ns/1ps
`default_nettype none

`include "des_params.svh"

module tb_des import des_pkg::*; ();

    localparam int CLK_PERIOD      = 40;
    localparam int DRIVE_DLY       = 2;
    localparam int NUM_RAND        = 32;
    localparam int NUM_COMP        = 4;
    localparam int TOTAL_BLOCKS    = 2 + 2 * NUM_RAND + 2 * NUM_COMP;
    localparam int WATCHDOG_CYCLES = (TOTAL_BLOCKS + 20) * 10;

    // FIPS known-answer vector
    localparam logic [`DES_KEY_W-1:0]   KAT_KEY   = 64'h133457799BBCDFF1;
    localparam logic [`DES_BLOCK_W-1:0] KAT_PT    = 64'h0123456789ABCDEF;
    localparam logic [`DES_BLOCK_W-1:0] KAT_CT    = 64'h85E813540F0AB405;
    localparam logic [31:0]             LFSR_SEED = 32'h08e0228e;

    typedef struct packed {
        logic                    chk;  // Compare data, not only timing
        logic [`DES_BLOCK_W-1:0] data;
        int                      cyc;  // Edge just before the strobe cycle
    } sb_entry_t;

    logic         ck;
    logic         rst_n;
    des_key_req_t key_req;
    des_block_t   in_blk;
    des_block_t   out_blk;

    int                      cyc = 0;
    logic [31:0]             lfsr;
    sb_entry_t               exp_q[$];
    logic [`DES_BLOCK_W-1:0] got_q[$];
    logic [`DES_BLOCK_W-1:0] pt[NUM_RAND];
    logic [`DES_BLOCK_W-1:0] ct[NUM_RAND];

    des_core dut_i (
        .ck      (ck),
        .rst_n   (rst_n),
        .key_req (key_req),
        .in_blk  (in_blk),
        .out_blk (out_blk)
    );

    initial ck = 1'b0;
    always #(CLK_PERIOD / 2) ck = ~ck;

    always @(posedge ck) begin
        cyc = cyc + 1;
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic rand_word(output logic [`DES_BLOCK_W-1:0] v);
        v = '0;
        for (int i = 0; i < `DES_BLOCK_W; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[`DES_BLOCK_W-2:0], lfsr[0]};
        end
    endtask

    task automatic check_eq(input logic [`DES_BLOCK_W-1:0] got,
                            input logic [`DES_BLOCK_W-1:0] want, input string msg);
        if (got !== want) begin
            $display("[ERROR] %0t ns: %s, got %h, expected %h", $time, msg, got, want);
            $display("TB FAILED");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    task automatic idle(input int n);
        repeat (n) @(posedge ck);
        #DRIVE_DLY;
    endtask

    task automatic load_key(input des_dir_e dir, input logic [`DES_KEY_W-1:0] key);
        key_req.valid = 1'b1;
        key_req.dir   = dir;
        key_req.key   = key;
        @(posedge ck);
        #DRIVE_DLY;
        key_req.valid = 1'b0;
    endtask

    task automatic send_block(input logic [`DES_BLOCK_W-1:0] data, input logic chk,
                              input logic [`DES_BLOCK_W-1:0] exp_data);
        in_blk.valid = 1'b1;
        in_blk.data  = data;
        exp_q.push_back('{chk: chk, data: exp_data, cyc: cyc});
        @(posedge ck);
        #DRIVE_DLY;
        in_blk.valid = 1'b0;
    endtask

    // Pipeline is empty once every expected result came out
    task automatic wait_drain();
        while (exp_q.size() != 0) @(negedge ck);
        idle(1);
    endtask

    // Scoreboard samples mid-cycle where outputs are stable
    always @(negedge ck) begin
        sb_entry_t ent;
        if (rst_n === 1'b1) begin
            if (out_blk.valid === 1'b1) begin
                check_eq(64'(exp_q.size() != 0), 64'd1, "output with no block in flight");
                ent = exp_q.pop_front();
                check_eq(64'(cyc - ent.cyc), 64'(`DES_LATENCY), "output latency in cycles");
                check_eq(64'($isunknown(out_blk.data)), 64'd0, "output data has unknown bits");
                if (ent.chk) begin
                    check_eq(out_blk.data, ent.data, "output data");
                end
                got_q.push_back(out_blk.data);
            end else begin
                check_eq(64'(out_blk.valid), 64'd0, "out_blk.valid unknown");
                if (exp_q.size() != 0) begin
                    check_eq(64'((cyc - exp_q[0].cyc) < `DES_LATENCY), 64'd1,
                             "output missing after latency");
                end
            end
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired before the test sequence finished");
        $display("TB FAILED");
        $fatal(1, "timeout");
    end

    initial begin
        logic [`DES_KEY_W-1:0]   key;
        logic [`DES_BLOCK_W-1:0] p;
        logic [`DES_BLOCK_W-1:0] c1;
        lfsr    = LFSR_SEED;
        rst_n   = 1'b0;
        key_req = '0;
        in_blk  = '0;
        repeat (2) @(posedge ck);
        #DRIVE_DLY;
        rst_n = 1'b1;
        idle(4); // Output must stay quiet here

        // Known answer both ways
        load_key(DES_ENCRYPT, KAT_KEY);
        send_block(KAT_PT, 1'b1, KAT_CT);
        wait_drain();
        load_key(DES_DECRYPT, KAT_KEY);
        send_block(KAT_CT, 1'b1, KAT_PT);
        wait_drain();

        // Back-to-back random round trip
        rand_word(key);
        load_key(DES_ENCRYPT, key);
        got_q.delete();
        for (int i = 0; i < NUM_RAND; i++) begin
            rand_word(pt[i]);
            send_block(pt[i], 1'b0, '0);
        end
        wait_drain();
        check_eq(64'(got_q.size()), 64'(NUM_RAND), "ciphertext count");
        for (int i = 0; i < NUM_RAND; i++) begin
            ct[i] = got_q[i];
        end
        load_key(DES_DECRYPT, key);
        for (int i = 0; i < NUM_RAND; i++) begin
            send_block(ct[i], 1'b1, pt[i]);
        end
        wait_drain();

        // E(~k, ~p) equals ~E(k, p)
        for (int n = 0; n < NUM_COMP; n++) begin
            rand_word(key);
            rand_word(p);
            load_key(DES_ENCRYPT, key);
            got_q.delete();
            send_block(p, 1'b0, '0);
            wait_drain();
            check_eq(64'(got_q.size()), 64'd1, "complement reference count");
            c1 = got_q.pop_front();
            load_key(DES_ENCRYPT, ~key);
            send_block(~p, 1'b1, ~c1);
            wait_drain();
        end

        if (exp_q.size() == 0) begin
            $display("TB PASSED");
            $finish;
        end else begin
            $display("[ERROR] %0t ns: %0d results never came out", $time, exp_q.size());
            $display("TB FAILED");
            $fatal(1, "scoreboard not empty");
        end
    end

endmodule

`default_nettype wire

// File: des_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "des_params.svh"

module des_core import des_pkg::*; (
    input  logic         ck,
    input  logic         rst_n,
    input  des_key_req_t key_req,
    input  des_block_t   in_blk,
    output des_block_t   out_blk
);

    localparam int IP_TBL [64] = '{
        58, 50, 42, 34, 26, 18, 10,  2, 60, 52, 44, 36, 28, 20, 12,  4,
        62, 54, 46, 38, 30, 22, 14,  6, 64, 56, 48, 40, 32, 24, 16,  8,
        57, 49, 41, 33, 25, 17,  9,  1, 59, 51, 43, 35, 27, 19, 11,  3,
        61, 53, 45, 37, 29, 21, 13,  5, 63, 55, 47, 39, 31, 23, 15,  7
    };

    // Inverse of IP
    localparam int FP_TBL [64] = '{
        40,  8, 48, 16, 56, 24, 64, 32, 39,  7, 47, 15, 55, 23, 63, 31,
        38,  6, 46, 14, 54, 22, 62, 30, 37,  5, 45, 13, 53, 21, 61, 29,
        36,  4, 44, 12, 52, 20, 60, 28, 35,  3, 43, 11, 51, 19, 59, 27,
        34,  2, 42, 10, 50, 18, 58, 26, 33,  1, 41,  9, 49, 17, 57, 25
    };

    des_subkeys_t            subkeys;
    des_group_keys_t         keys_lo;
    des_group_keys_t         keys_hi;
    logic [`DES_BLOCK_W-1:0] ip_data;
    logic [`DES_BLOCK_W-1:0] pre_out;
    logic [`DES_BLOCK_W-1:0] fp_data;
    des_block_t              ip_blk;
    des_block_t              grp_lo_blk;
    des_block_t              grp_hi_blk;

    des_key_schedule key_sched_i (
        .ck      (ck),
        .rst_n   (rst_n),
        .key_req (key_req),
        .subkeys (subkeys)
    );

    always_comb begin
        for (int i = 0; i < `DES_BLOCK_W; i++) begin
            ip_data[`DES_BLOCK_W-1-i] = in_blk.data[`DES_BLOCK_W - IP_TBL[i]];
        end
    end

    // Stage 1
    always_ff @(posedge ck) begin
        if (in_blk.valid) begin
            ip_blk.data <= ip_data;
        end
        if (!rst_n) begin
            ip_blk.valid <= 1'b0;
        end else begin
            ip_blk.valid <= in_blk.valid;
        end
    end

    assign keys_lo = subkeys[`DES_GROUP_ROUNDS-1:0];
    assign keys_hi = subkeys[`DES_ROUNDS-1:`DES_GROUP_ROUNDS];

    des_round_group grp_lo_i (
        .ck      (ck),
        .rst_n   (rst_n),
        .blk_in  (ip_blk),
        .keys    (keys_lo),
        .blk_out (grp_lo_blk)
    );

    des_round_group grp_hi_i (
        .ck      (ck),
        .rst_n   (rst_n),
        .blk_in  (grp_lo_blk),
        .keys    (keys_hi),
        .blk_out (grp_hi_blk)
    );

    // Undo the last round's swap, R16 goes on top
    assign pre_out = {grp_hi_blk.data[`DES_HALF_W-1:0],
                      grp_hi_blk.data[`DES_BLOCK_W-1:`DES_HALF_W]};

    always_comb begin
        for (int i = 0; i < `DES_BLOCK_W; i++) begin
            fp_data[`DES_BLOCK_W-1-i] = pre_out[`DES_BLOCK_W - FP_TBL[i]];
        end
    end

    // Stage 4
    always_ff @(posedge ck) begin
        if (grp_hi_blk.valid) begin
            out_blk.data <= fp_data;
        end
        if (!rst_n) begin
            out_blk.valid <= 1'b0;
        end else begin
            out_blk.valid <= grp_hi_blk.valid;
        end
    end

endmodule

`default_nettype wire

// File: des_key_schedule.sv
`timescale 1ns/1ps
`default_nettype none

`include "des_params.svh"

module des_key_schedule import des_pkg::*; (
    input  logic         ck,
    input  logic         rst_n,
    input  des_key_req_t key_req,
    output des_subkeys_t subkeys
);

    localparam int CD_HALF = `DES_CD_W / 2;

    // PC-1 drops the parity bits
    localparam int PC1_TBL [56] = '{
        57, 49, 41, 33, 25, 17,  9,  1, 58, 50, 42, 34, 26, 18,
        10,  2, 59, 51, 43, 35, 27, 19, 11,  3, 60, 52, 44, 36,
        63, 55, 47, 39, 31, 23, 15,  7, 62, 54, 46, 38, 30, 22,
        14,  6, 61, 53, 45, 37, 29, 21, 13,  5, 28, 20, 12,  4
    };

    logic [`DES_CD_W-1:0] cd_pc1;
    logic [CD_HALF-1:0]   c_rot;
    logic [CD_HALF-1:0]   d_rot;
    des_subkeys_t         ks_fwd;

    always_comb begin
        for (int i = 0; i < `DES_CD_W; i++) begin
            cd_pc1[`DES_CD_W-1-i] = key_req.key[`DES_KEY_W - PC1_TBL[i]];
        end
        c_rot = cd_pc1[`DES_CD_W-1:CD_HALF];
        d_rot = cd_pc1[CD_HALF-1:0];
        // Whole schedule unrolled in one cycle
        for (int r = 0; r < `DES_ROUNDS; r++) begin
            if (r == 0 || r == 1 || r == 8 || r == `DES_ROUNDS - 1) begin
                c_rot = {c_rot[CD_HALF-2:0], c_rot[CD_HALF-1]};
                d_rot = {d_rot[CD_HALF-2:0], d_rot[CD_HALF-1]};
            end else begin
                c_rot = {c_rot[CD_HALF-3:0], c_rot[CD_HALF-1:CD_HALF-2]};
                d_rot = {d_rot[CD_HALF-3:0], d_rot[CD_HALF-1:CD_HALF-2]};
            end
            ks_fwd[r] = des_pc2({c_rot, d_rot});
        end
    end

    always_ff @(posedge ck) begin
        if (!rst_n) begin
            subkeys <= '0;
        end else if (key_req.valid) begin
            for (int r = 0; r < `DES_ROUNDS; r++) begin
                if (key_req.dir == DES_ENCRYPT) begin
                    subkeys[r] <= ks_fwd[r];
                end else begin
                    subkeys[r] <= ks_fwd[`DES_ROUNDS-1-r]; // Reverse order
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: des_round_group.sv
`timescale 1ns/1ps
`default_nettype none

`include "des_params.svh"

module des_round_group import des_pkg::*; (
    input  logic            ck,
    input  logic            rst_n,
    input  des_block_t      blk_in,
    input  des_group_keys_t keys,
    output des_block_t      blk_out
);

    logic [`DES_GROUP_ROUNDS:0][`DES_BLOCK_W-1:0] chain;

    assign chain[0] = blk_in.data;

    for (genvar g = 0; g < `DES_GROUP_ROUNDS; g++) begin : g_round
        des_round round_i (
            .half_in  (chain[g]),
            .subkey   (keys[g]),
            .half_out (chain[g+1])
        );
    end

    always_ff @(posedge ck) begin
        if (blk_in.valid) begin
            blk_out.data <= chain[`DES_GROUP_ROUNDS]; // Capture only real blocks
        end
        if (!rst_n) begin
            blk_out.valid <= 1'b0;
        end else begin
            blk_out.valid <= blk_in.valid;
        end
    end

endmodule

`default_nettype wire

// File: des_round.sv
`timescale 1ns/1ps
`default_nettype none

`include "des_params.svh"

module des_round import des_pkg::*; (
    input  logic [`DES_BLOCK_W-1:0]  half_in,
    input  logic [`DES_SUBKEY_W-1:0] subkey,
    output logic [`DES_BLOCK_W-1:0]  half_out
);

    localparam int NUM_SBOX = 8;

    logic [`DES_HALF_W-1:0]   l_in;
    logic [`DES_HALF_W-1:0]   r_in;
    logic [`DES_SUBKEY_W-1:0] mixed;
    logic [`DES_HALF_W-1:0]   sb_out;
    logic [`DES_HALF_W-1:0]   f_out;

    assign l_in = half_in[`DES_BLOCK_W-1:`DES_HALF_W];
    assign r_in = half_in[`DES_HALF_W-1:0];

    assign mixed = des_expand(r_in) ^ subkey; // Key mix

    // Box 0 takes the top six bits
    always_comb begin
        for (int j = 0; j < NUM_SBOX; j++) begin
            sb_out[`DES_HALF_W-1-4*j -: 4] = des_sbox(3'(j), mixed[`DES_SUBKEY_W-1-6*j -: 6]);
        end
    end

    assign f_out = des_perm_p(sb_out);

    assign half_out = {r_in, l_in ^ f_out}; // New L, new R

endmodule

`default_nettype wire

// File: des_pkg.sv
`default_nettype none

`include "des_params.svh"

package des_pkg;

    typedef enum logic {
        DES_ENCRYPT = 1'b0,
        DES_DECRYPT = 1'b1
    } des_dir_e;

    typedef struct packed {
        logic                  valid; // Strobe
        des_dir_e              dir;
        logic [`DES_KEY_W-1:0] key;
    } des_key_req_t;

    typedef struct packed {
        logic                    valid;
        logic [`DES_BLOCK_W-1:0] data;
    } des_block_t;

    // Entry 0 feeds the first round
    typedef logic [`DES_ROUNDS-1:0][`DES_SUBKEY_W-1:0] des_subkeys_t;
    typedef logic [`DES_GROUP_ROUNDS-1:0][`DES_SUBKEY_W-1:0] des_group_keys_t;

    // Tables use FIPS numbering, bit 1 is the MSB
    localparam int E_TBL [48] = '{
        32,  1,  2,  3,  4,  5,  4,  5,  6,  7,  8,  9,
         8,  9, 10, 11, 12, 13, 12, 13, 14, 15, 16, 17,
        16, 17, 18, 19, 20, 21, 20, 21, 22, 23, 24, 25,
        24, 25, 26, 27, 28, 29, 28, 29, 30, 31, 32,  1
    };

    localparam int P_TBL [32] = '{
        16,  7, 20, 21, 29, 12, 28, 17,  1, 15, 23, 26,  5, 18, 31, 10,
         2,  8, 24, 14, 32, 27,  3,  9, 19, 13, 30,  6, 22, 11,  4, 25
    };

    localparam int PC2_TBL [48] = '{
        14, 17, 11, 24,  1,  5,  3, 28, 15,  6, 21, 10,
        23, 19, 12,  4, 26,  8, 16,  7, 27, 20, 13,  2,
        41, 52, 31, 37, 47, 55, 30, 40, 51, 45, 33, 48,
        44, 49, 39, 56, 34, 53, 46, 42, 50, 36, 29, 32
    };

    // One 256-bit constant per box, row 0 first, column 0 in the top nibble
    function automatic logic [3:0] des_sbox(input logic [2:0] box, input logic [5:0] in6);
        logic [255:0] tbl;
        logic [5:0]   idx;
        case (box)
            3'd0: tbl = {64'hE4D12FB83A6C5907, 64'h0F74E2D1A6CB9538,
                         64'h41E8D62BFC973A50, 64'hFC8249175B3EA06D};
            3'd1: tbl = {64'hF18E6B34972DC05A, 64'h3D47F28EC01A69B5,
                         64'h0E7BA4D158C6932F, 64'hD8A13F42B67C05E9};
            3'd2: tbl = {64'hA09E63F51DC7B428, 64'hD709346A285ECBF1,
                         64'hD6498F30B12C5AE7, 64'h1AD069874FE3B52C};
            3'd3: tbl = {64'h7DE3069A1285BC4F, 64'hD8B56F03472C1AE9,
                         64'hA690CB7DF13E5284, 64'h3F06A1D8945BC72E};
            3'd4: tbl = {64'h2C417AB6853FD0E9, 64'hEB2C47D150FA3986,
                         64'h421BAD78F9C5630E, 64'hB8C71E2D6F09A453};
            3'd5: tbl = {64'hC1AF92680D34E75B, 64'hAF427C9561DE0B38,
                         64'h9EF528C3704A1DB6, 64'h432C95FABE17608D};
            3'd6: tbl = {64'h4B2EF08D3C975A61, 64'hD0B7491AE35C2F86,
                         64'h14BDC37EAF680592, 64'h6BD814A7950FE23C};
            default: tbl = {64'hD2846FB1A93E50C7, 64'h1FD8A374C56B0E92,
                            64'h7B419CE206ADF358, 64'h21E74A8DFC90356B};
        endcase
        idx = {in6[5], in6[0], in6[4:1]}; // Row from outer bits
        return tbl[255 - 4 * idx -: 4];
    endfunction

    function automatic logic [`DES_SUBKEY_W-1:0] des_expand(input logic [`DES_HALF_W-1:0] r);
        logic [`DES_SUBKEY_W-1:0] e;
        for (int i = 0; i < `DES_SUBKEY_W; i++) begin
            e[`DES_SUBKEY_W-1-i] = r[`DES_HALF_W - E_TBL[i]];
        end
        return e;
    endfunction

    function automatic logic [`DES_HALF_W-1:0] des_perm_p(input logic [`DES_HALF_W-1:0] s);
        logic [`DES_HALF_W-1:0] p;
        for (int i = 0; i < `DES_HALF_W; i++) begin
            p[`DES_HALF_W-1-i] = s[`DES_HALF_W - P_TBL[i]];
        end
        return p;
    endfunction

    function automatic logic [`DES_SUBKEY_W-1:0] des_pc2(input logic [`DES_CD_W-1:0] cd);
        logic [`DES_SUBKEY_W-1:0] k;
        for (int i = 0; i < `DES_SUBKEY_W; i++) begin
            k[`DES_SUBKEY_W-1-i] = cd[`DES_CD_W - PC2_TBL[i]];
        end
        return k;
    endfunction

endpackage

`default_nettype wire

// File: des_params.svh
`ifndef DES_PARAMS_SVH
`define DES_PARAMS_SVH

// Block and half widths
`define DES_BLOCK_W 64
`define DES_HALF_W 32

// Key with parity bits, and the C/D pair after PC-1
`define DES_KEY_W 64
`define DES_CD_W 56

`define DES_SUBKEY_W 48

// Sixteen rounds split over two pipeline stages
`define DES_ROUNDS 16
`define DES_GROUP_ROUNDS 8

// IP, two round groups, FP
`define DES_LATENCY 4

`endif
